// File: common/noc_pkg.sv
package noc_pkg;

    // router geometry, fixed by the 2D mesh
    localparam int NUM_PORTS = 5;   // local plus the four mesh neighbours
    localparam int COORD_W = 3;     // 8 by 8 mesh
    localparam int DATA_W = 16;

    // the enum value is the bit index in every request and grant vector
    typedef enum logic [2:0] {
        port_local = 3'd0,
        port_east  = 3'd1,
        port_west  = 3'd2,
        port_north = 3'd3,
        port_south = 3'd4
    } port_dir_e;

    // one bit per port, indexed by port_dir_e
    typedef logic [NUM_PORTS-1:0] port_vec_t;

    // a single-flit packet as it enters and leaves the router
    typedef struct packed {
        logic               valid;
        logic [COORD_W-1:0] dest_x;
        logic [COORD_W-1:0] dest_y;
        logic [DATA_W-1:0]  payload;
    } flit_t;

endpackage

// File: router/route_compute.sv
`timescale 1ns/100ps

module route_compute #(
    parameter int ROUTER_X = 0,
    parameter int ROUTER_Y = 0
) (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  noc_pkg::flit_t     [noc_pkg::NUM_PORTS-1:0] flit_in,
    output noc_pkg::flit_t     [noc_pkg::NUM_PORTS-1:0] flit_q,
    output noc_pkg::port_vec_t [noc_pkg::NUM_PORTS-1:0] dest_req
);

    import noc_pkg::*;

    // this router's place in the mesh, at coordinate width
    localparam logic [COORD_W-1:0] OWN_X = COORD_W'(ROUTER_X);
    localparam logic [COORD_W-1:0] OWN_Y = COORD_W'(ROUTER_Y);

    port_vec_t [NUM_PORTS-1:0] route_next;

    // dimension order routing, x is resolved completely before y
    function automatic port_vec_t xy_route(input flit_t f);
        port_vec_t req;
        req = '0;
        if (f.valid) begin
            if (f.dest_x > OWN_X) begin
                req[port_east] = 1'b1;
            end else if (f.dest_x < OWN_X) begin
                req[port_west] = 1'b1;
            end else if (f.dest_y > OWN_Y) begin
                req[port_north] = 1'b1;
            end else if (f.dest_y < OWN_Y) begin
                req[port_south] = 1'b1;
            end else begin
                req[port_local] = 1'b1;   // arrived at its destination
            end
        end
        return req;
    endfunction

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            route_next[p] = xy_route(flit_in[p]);
        end
    end

    // flits and their requests move together into the allocation stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flit_q   <= '0;
            dest_req <= '0;
        end else begin
            flit_q   <= flit_in;
            dest_req <= route_next;
        end
    end

endmodule

// File: router/round_arbiter.sv
`timescale 1ns/100ps

module round_arbiter #(
    parameter int WIDTH = 5
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] request,
    output logic [WIDTH-1:0] grant
);

    logic [WIDTH-1:0] grant_next;

    // the last grant doubles as the rotation pointer
    always_comb begin
        int last_idx;
        int start_idx;
        int idx;
        logic found;

        last_idx = 0;
        found = 1'b0;
        grant_next = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (grant[i]) last_idx = i;
        end

        start_idx = (grant == '0) ? 0 : last_idx + 1;   // idle arbiter starts from input 0
        for (int k = 0; k < WIDTH; k++) begin
            idx = start_idx + k;
            if (idx >= WIDTH) idx = idx - WIDTH;
            if (!found && request[idx]) begin
                grant_next[idx] = 1'b1;
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant <= '0;
        end else begin
            grant <= grant_next;
        end
    end

endmodule

// File: router/sw_alloc.sv
`timescale 1ns/100ps

module sw_alloc (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  noc_pkg::port_vec_t [noc_pkg::NUM_PORTS-1:0] dest_req,
    input  noc_pkg::port_vec_t                           outport_available,
    output noc_pkg::port_vec_t [noc_pkg::NUM_PORTS-1:0] grant_by_out,
    output noc_pkg::port_vec_t [noc_pkg::NUM_PORTS-1:0] grant_by_in
);

    import noc_pkg::*;

    port_vec_t [NUM_PORTS-1:0] req_masked;   // indexed by input
    port_vec_t [NUM_PORTS-1:0] out_req;      // indexed by output

    genvar i, o;
    generate
        for (i = 0; i < NUM_PORTS; i++) begin : g_in_mask
            // a busy output takes no requests this cycle
            assign req_masked[i] = dest_req[i] & outport_available;
        end

        for (o = 0; o < NUM_PORTS; o++) begin : g_out
            for (i = 0; i < NUM_PORTS; i++) begin : g_in
                assign out_req[o][i]     = req_masked[i][o];
                assign grant_by_in[i][o] = grant_by_out[o][i];
            end

            round_arbiter #(
                .WIDTH(NUM_PORTS)
            ) u_out_arbiter (
                .clk     (clk),
                .rst_n   (rst_n),
                .request (out_req[o]),
                .grant   (grant_by_out[o])
            );
        end
    endgenerate

endmodule

// File: router/crossbar.sv
`timescale 1ns/100ps

module crossbar (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  noc_pkg::flit_t     [noc_pkg::NUM_PORTS-1:0] flit_q,
    input  noc_pkg::port_vec_t [noc_pkg::NUM_PORTS-1:0] grant_by_out,
    input  noc_pkg::port_vec_t [noc_pkg::NUM_PORTS-1:0] grant_by_in,
    output noc_pkg::flit_t     [noc_pkg::NUM_PORTS-1:0] flit_out,
    output noc_pkg::port_vec_t                           in_grant
);

    import noc_pkg::*;

    flit_t     [NUM_PORTS-1:0] flit_hold;   // flits that competed in the arbiters
    flit_t     [NUM_PORTS-1:0] out_next;
    port_vec_t                 in_grant_next;

    // one cycle behind flit_q so each flit meets its own grant
    always_ff @(posedge clk) begin
        flit_hold <= flit_q;
    end

    always_comb begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            out_next[o] = '0;   // no winner means an invalid, empty flit
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (grant_by_out[o][i]) begin
                    out_next[o] = flit_hold[i];
                end
            end
        end
    end

    // tells each sender whether its flit left the router
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            in_grant_next[i] = |grant_by_in[i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flit_out <= '0;
            in_grant <= '0;
        end else begin
            flit_out <= out_next;
            in_grant <= in_grant_next;
        end
    end

endmodule

// File: hdl/noc_router.sv
`timescale 1ns/100ps

module noc_router #(
    parameter int ROUTER_X = 0,
    parameter int ROUTER_Y = 0
) (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  noc_pkg::flit_t     [noc_pkg::NUM_PORTS-1:0] flit_in,
    input  noc_pkg::port_vec_t                           outport_available,
    output noc_pkg::flit_t     [noc_pkg::NUM_PORTS-1:0] flit_out,
    output noc_pkg::port_vec_t                           in_grant
);

    import noc_pkg::*;

    flit_t     [NUM_PORTS-1:0] flit_q;         // registered input flits
    port_vec_t [NUM_PORTS-1:0] dest_req;       // one-hot XY request per input
    port_vec_t [NUM_PORTS-1:0] grant_by_out;   // winning input per output
    port_vec_t [NUM_PORTS-1:0] grant_by_in;    // won output per input

    // decode
    route_compute #(
        .ROUTER_X (ROUTER_X),
        .ROUTER_Y (ROUTER_Y)
    ) u_route_compute (
        .clk      (clk),
        .rst_n    (rst_n),
        .flit_in  (flit_in),
        .flit_q   (flit_q),
        .dest_req (dest_req)
    );

    // execute
    sw_alloc u_sw_alloc (
        .clk               (clk),
        .rst_n             (rst_n),
        .dest_req          (dest_req),
        .outport_available (outport_available),
        .grant_by_out      (grant_by_out),
        .grant_by_in       (grant_by_in)
    );

    // result, two edges after the flits were sampled
    crossbar u_crossbar (
        .clk          (clk),
        .rst_n        (rst_n),
        .flit_q       (flit_q),
        .grant_by_out (grant_by_out),
        .grant_by_in  (grant_by_in),
        .flit_out     (flit_out),
        .in_grant     (in_grant)
    );

endmodule

// File: verif/tb_noc_router.sv
`timescale 1ns/100ps

module tb_noc_router;

    import noc_pkg::*;

    localparam int FIELDS = 32;          // hex words on one line of the data file
    localparam int ADDR_W = 11;
    localparam int MEM_WORDS = 1 << ADDR_W;
    localparam int MAX_LINES = MEM_WORDS / FIELDS;
    localparam int MASK_FIELD = 20;
    localparam int EXP_FIELD = 21;       // first expected valid/payload pair
    localparam int GRANT_FIELD = 31;

    logic                      clk;
    logic                      rst_n;
    flit_t     [NUM_PORTS-1:0] flit_in;
    port_vec_t                 outport_available;
    flit_t     [NUM_PORTS-1:0] flit_out;
    port_vec_t                 in_grant;

    logic [15:0] stim_mem [0:MEM_WORDS-1];
    int          num_lines;
    int          cycle_count;
    int          cycle_limit;
    int          check_count;
    int          flit_errors;
    int          grant_errors;
    int          setup_errors;

    noc_router #(
        .ROUTER_X (3),
        .ROUTER_Y (3)
    ) uut (
        .clk               (clk),
        .rst_n             (rst_n),
        .flit_in           (flit_in),
        .outport_available (outport_available),
        .flit_out          (flit_out),
        .in_grant          (in_grant)
    );

    always #2 clk = ~clk;

    // the run may not outlast the data file by much
    always @(posedge clk) begin
        if (rst_n) begin
            cycle_count <= cycle_count + 1;
            if (cycle_count >= cycle_limit) begin
                $display("timeout after %0d cycles, the test did not reach its end", cycle_count);
                $display("Simulation failed");
                $finish;
            end
        end
    end

    function automatic logic [15:0] stim_field(input int line, input int idx);
        return stim_mem[ADDR_W'(line * FIELDS + idx)];
    endfunction

    function automatic string describe_flit(input flit_t f);
        return $sformatf("valid %0b dest %0d,%0d payload %h", f.valid, f.dest_x, f.dest_y,
                         f.payload);
    endfunction

    // lines outside the file are idle cycles
    task automatic apply_flits(input int line);
        flit_in = '0;
        if (line >= 0 && line < num_lines) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                flit_in[p].valid   = 1'(stim_field(line, 4 * p));
                flit_in[p].dest_x  = COORD_W'(stim_field(line, 4 * p + 1));
                flit_in[p].dest_y  = COORD_W'(stim_field(line, 4 * p + 2));
                flit_in[p].payload = stim_field(line, 4 * p + 3);
            end
        end
    endtask

    // the mask is applied one cycle after its flits, while their requests sit in the arbiters
    task automatic apply_mask(input int line);
        if (line >= 0 && line < num_lines) begin
            outport_available = port_vec_t'(stim_field(line, MASK_FIELD));
        end else begin
            outport_available = '1;
        end
    endtask

    task automatic check_outputs(
        input string                     what,
        input flit_t     [NUM_PORTS-1:0] exp_flit,
        input port_vec_t                 exp_grant
    );
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_count++;
            assert (flit_out[p] === exp_flit[p]) else begin
                flit_errors++;
                $display("Error at %0d ns: %s, flit_out[%0d] is %s, expected %s",
                         $time, what, p, describe_flit(flit_out[p]),
                         describe_flit(exp_flit[p]));
            end
        end
        check_count++;
        assert (in_grant === exp_grant) else begin
            grant_errors++;
            $display("Error at %0d ns: %s, in_grant is %b, expected %b",
                     $time, what, in_grant, exp_grant);
        end
    endtask

    task automatic check_line(input int line);
        flit_t     [NUM_PORTS-1:0] exp_flit;
        port_vec_t                 exp_grant;
        exp_flit = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            exp_flit[p].valid   = 1'(stim_field(line, EXP_FIELD + 2 * p));
            exp_flit[p].payload = stim_field(line, EXP_FIELD + 2 * p + 1);
            // a routed flit keeps the coordinates it was sent with
            if (exp_flit[p].valid) begin
                for (int i = 0; i < NUM_PORTS; i++) begin
                    if (1'(stim_field(line, 4 * i)) == 1'b1
                        && stim_field(line, 4 * i + 3) == exp_flit[p].payload) begin
                        exp_flit[p].dest_x = COORD_W'(stim_field(line, 4 * i + 1));
                        exp_flit[p].dest_y = COORD_W'(stim_field(line, 4 * i + 2));
                    end
                end
            end
        end
        exp_grant = port_vec_t'(stim_field(line, GRANT_FIELD));
        check_outputs($sformatf("data line %0d", line), exp_flit, exp_grant);
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        flit_in = '0;
        outport_available = '1;
        cycle_count = 0;
        cycle_limit = MAX_LINES + 20;
        check_count = 0;
        flit_errors = 0;
        grant_errors = 0;
        setup_errors = 0;
        num_lines = 0;

        // valid fields are 0 or 1 and no fill word is, so the fill marks where the file ends
        for (int a = 0; a < MEM_WORDS; a++) begin
            stim_mem[ADDR_W'(a)] = 16'hf800 | 16'(a);
        end
        $readmemh("verif/router_input.txt", stim_mem);
        while (num_lines < MAX_LINES && stim_field(num_lines, 0) <= 16'h0001) begin
            num_lines++;
        end
        cycle_limit = num_lines + 20;
        if (num_lines == 0) begin
            $display("no stimulus lines could be read from verif/router_input.txt");
            setup_errors++;
        end

        repeat (8) begin
            @(negedge clk);
            check_outputs("during reset", '0, '0);
        end
        rst_n = 1'b1;

        // line k is sampled at the next rising edge and leaves the router two edges later
        for (int k = 0; k < num_lines + 3; k++) begin
            @(negedge clk);
            if (k >= 3) begin
                check_line(k - 3);
            end else begin
                check_outputs($sformatf("idle cycle %0d after reset", k), '0, '0);
            end
            apply_flits(k);
            apply_mask(k - 1);
        end

        $display("checks %0d, flit errors %0d, grant errors %0d, setup errors %0d",
                 check_count, flit_errors, grant_errors, setup_errors);
        if (flit_errors + grant_errors + setup_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verif/router_input.txt
// inputs 0..4 (local east west north south): valid dest_x dest_y payload, then outport_available
// then expected flit_out 0..4 as valid payload, then expected in_grant; hex, one line per cycle
0 0 0 0000 0 0 0 0000 0 0 0 0000 0 0 0 0000 0 0 0 0000  1f  0 0000 0 0000 0 0000 0 0000 0 0000  00
1 5 3 1101 0 0 0 0000 0 0 0 0000 0 0 0 0000 0 0 0 0000  1f  0 0000 1 1101 0 0000 0 0000 0 0000  01
0 0 0 0000 1 0 3 1202 0 0 0 0000 0 0 0 0000 0 0 0 0000  1f  0 0000 0 0000 1 1202 0 0000 0 0000  02
0 0 0 0000 0 0 0 0000 1 3 6 1303 0 0 0 0000 0 0 0 0000  1f  0 0000 0 0000 0 0000 1 1303 0 0000  04
0 0 0 0000 0 0 0 0000 0 0 0 0000 1 3 0 1404 0 0 0 0000  1f  0 0000 0 0000 0 0000 0 0000 1 1404  08
0 0 0 0000 0 0 0 0000 0 0 0 0000 0 0 0 0000 1 3 3 1505  1f  1 1505 0 0000 0 0000 0 0000 0 0000  10
1 6 7 1606 0 0 0 0000 0 0 0 0000 0 0 0 0000 0 0 0 0000  1f  0 0000 1 1606 0 0000 0 0000 0 0000  01
0 0 0 0000 0 0 0 0000 0 0 0 0000 1 1 0 1707 0 0 0 0000  1f  0 0000 0 0000 1 1707 0 0000 0 0000  08
0 0 0 0000 0 0 0 0000 0 0 0 0000 0 0 0 0000 0 0 0 0000  1f  0 0000 0 0000 0 0000 0 0000 0 0000  00
1 7 2 2900 1 4 4 2901 1 5 0 2902 0 0 0 0000 0 0 0 0000  1f  0 0000 1 2900 0 0000 0 0000 0 0000  01
1 7 2 2a00 1 4 4 2a01 1 5 0 2a02 0 0 0 0000 0 0 0 0000  1f  0 0000 1 2a01 0 0000 0 0000 0 0000  02
1 7 2 2b00 1 4 4 2b01 1 5 0 2b02 0 0 0 0000 0 0 0 0000  1f  0 0000 1 2b02 0 0000 0 0000 0 0000  04
1 7 2 2c00 1 4 4 2c01 1 5 0 2c02 0 0 0 0000 0 0 0 0000  1f  0 0000 1 2c00 0 0000 0 0000 0 0000  01
0 0 0 0000 0 0 0 0000 1 5 0 2d02 0 0 0 0000 1 6 1 2d04  1f  0 0000 1 2d02 0 0000 0 0000 0 0000  04
1 0 2 2e10 0 0 0 0000 1 5 0 2e02 1 1 5 2e13 0 0 0 0000  1f  0 0000 1 2e02 1 2e10 0 0000 0 0000  05
1 2 3 2f10 0 0 0 0000 0 0 0 0000 1 0 7 2f13 0 0 0 0000  1f  0 0000 0 0000 1 2f13 0 0000 0 0000  08
1 0 0 3010 0 0 0 0000 0 0 0 0000 1 2 2 3013 1 1 4 3014  1f  0 0000 0 0000 1 3014 0 0000 0 0000  10
1 7 3 4100 1 0 3 4101 1 3 7 4102 1 3 1 4103 1 3 3 4104  1f  1 4104 1 4100 1 4101 1 4102 1 4103  1f
1 0 1 4200 1 3 4 4201 1 3 2 4202 1 3 3 4203 1 4 6 4204  1f  1 4203 1 4204 1 4200 1 4201 1 4202  1f
1 3 5 4300 1 3 0 4301 1 3 3 4302 1 6 3 4303 1 1 1 4304  1f  1 4302 1 4303 1 4304 1 4300 1 4301  1f
1 3 5 5000 1 3 4 5001 1 7 7 5002 0 0 0 0000 0 0 0 0000  17  0 0000 1 5002 0 0000 0 0000 0 0000  04
1 3 6 5100 1 3 7 5101 0 0 0 0000 0 0 0 0000 1 3 4 5104  1f  0 0000 0 0000 0 0000 1 5100 0 0000  01
0 0 0 0000 1 3 5 5201 0 0 0 0000 1 4 4 5203 0 0 0 0000  1d  0 0000 0 0000 0 0000 1 5201 0 0000  02
1 3 3 5300 1 3 1 5301 0 0 0 0000 0 0 0 0000 0 0 0 0000  00  0 0000 0 0000 0 0000 0 0000 0 0000  00
0 0 0 0000 1 3 0 6001 1 3 2 6002 0 0 0 0000 0 0 0 0000  1f  0 0000 0 0000 0 0000 0 0000 1 6001  02
0 0 0 0000 0 0 0 0000 0 0 0 0000 0 0 0 0000 0 0 0 0000  1f  0 0000 0 0000 0 0000 0 0000 0 0000  00
0 0 0 0000 1 3 1 6201 1 3 0 6202 0 0 0 0000 0 0 0 0000  1f  0 0000 0 0000 0 0000 0 0000 1 6201  02
0 0 0 0000 1 3 2 6301 1 3 1 6302 0 0 0 0000 0 0 0 0000  1f  0 0000 0 0000 0 0000 0 0000 1 6302  04
0 0 0 0000 0 0 0 0000 0 0 0 0000 0 0 0 0000 0 0 0 0000  1f  0 0000 0 0000 0 0000 0 0000 0 0000  00
0 7 7 ffff 0 0 0 0000 0 3 3 abcd 0 0 0 0000 0 0 0 0000  1f  0 0000 0 0000 0 0000 0 0000 0 0000  00

// File: sim.f
common/noc_pkg.sv
router/route_compute.sv
router/round_arbiter.sv
router/sw_alloc.sv
router/crossbar.sv
hdl/noc_router.sv
verif/tb_noc_router.sv

// File: Makefile
SRCS := $(shell cat sim.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_noc_router: sim.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module tb_noc_router -f sim.f

run: obj_dir/Vtb_noc_router
	@out="$$(./obj_dir/Vtb_noc_router)"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation completed successfully"

clean:
	rm -rf obj_dir
